// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ooo_core
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "RESULT: PASS" $(LOG) || { echo "No result line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== flist.f ====
+incdir+verilog
verilog/ooo_pkg.sv
verilog/int_exec.sv
verilog/div_exec.sv
verilog/cdb_arbiter.sv
verilog/reorder_buffer.sv
verilog/ooo_core_top.sv
verif/tb_clk_gen.sv
verif/tb_ooo_core.sv

// ==== verif/tb_clk_gen.sv ====
module tb_clk_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                     // 100 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);                  // Hold reset 8 cycles
        rst <= 1'b0;
    end
endmodule

// ==== verif/tb_ooo_core.sv ====
`include "ooo_settings.svh"

module tb_ooo_core import ooo_pkg::*; ;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NROWS          = 20;
    localparam int TIMEOUT_CYCLES = NROWS * (`OOO_DIV_CYCLES + 20) + 50;

    typedef struct packed {
        logic [4:0]           dest;
        logic [`OOO_XLEN-1:0] value;
    } exp_t;

    logic        clk, rst;
    logic        disp_req, disp_ack;
    disp_t       disp;
    commit_t     commit;
    disp_t       rows [NROWS];                      // Stimulus table
    exp_t        exp_q [$];                         // Expected, program order
    exp_t        e;
    tag_t        exp_tag;
    int          errors, committed, cycles;
    int unsigned gap;

    tb_clk_gen i_tb_clk_gen (.clk(clk), .rst(rst));

    ooo_core_top i_ooo_core_top (
        .clk      (clk),
        .rst      (rst),
        .disp_req (disp_req),
        .disp     (disp),
        .disp_ack (disp_ack),
        .commit   (commit)
    );

    // Reference rules, 32-bit wrap everywhere
    function automatic logic [`OOO_XLEN-1:0] expected_result(input disp_t d);
        case (d.op)
            OP_ADD:  return d.a + d.b;
            OP_SUB:  return d.a - d.b;
            OP_AND:  return d.a & d.b;
            OP_OR:   return d.a | d.b;
            OP_XOR:  return d.a ^ d.b;
            OP_MUL:  return d.a * d.b;              // Low half of product
            OP_DIV:  return (d.b == '0) ? '1 : d.a / d.b;
            default: return 'x;
        endcase
    endfunction

    task automatic check_equal(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("Fail %0t: %s got %h expected %h", $time, what, got, expected);
            errors++;
        end
    endtask

    task automatic load_rows();
        rows[0]  = '{OP_ADD, 32'd5,         32'd7,         5'd1};
        rows[1]  = '{OP_SUB, 32'd3,         32'd10,        5'd2};   // Wraps negative
        rows[2]  = '{OP_AND, 32'hf0f0f0f0,  32'hff00ff00,  5'd3};
        rows[3]  = '{OP_OR,  32'h12340000,  32'h00005678,  5'd4};
        rows[4]  = '{OP_XOR, 32'haaaaaaaa,  32'hffff0000,  5'd5};
        rows[5]  = '{OP_MUL, 32'h12345678,  32'h9abcdef0,  5'd6};
        rows[6]  = '{OP_DIV, 32'd100,       32'd7,         5'd7};   // Adds behind finish first
        rows[7]  = '{OP_ADD, 32'd1,         32'd1,         5'd8};
        rows[8]  = '{OP_ADD, 32'hffffffff,  32'd1,         5'd9};
        rows[9]  = '{OP_SUB, 32'd0,         32'd1,         5'd10};
        rows[10] = '{OP_DIV, 32'hdeadbeef,  32'd0,         5'd11};  // Zero divisor
        rows[11] = '{OP_DIV, 32'hffffffff,  32'd3,         5'd12};  // Div run, back-pressure
        rows[12] = '{OP_DIV, 32'd7,         32'd9,         5'd13};
        rows[13] = '{OP_MUL, 32'hffffffff,  32'hffffffff,  5'd14};
        rows[14] = '{OP_XOR, 32'h0f0f0f0f,  32'h0f0f0f0f,  5'd15};
        rows[15] = '{OP_DIV, 32'd1000000,   32'd1000,      5'd16};
        rows[16] = '{OP_ADD, 32'h7fffffff,  32'd1,         5'd17};
        rows[17] = '{OP_MUL, 32'h00010000,  32'h00010000,  5'd18};  // Product fully wraps
        rows[18] = '{OP_OR,  32'd0,         32'd0,         5'd19};
        rows[19] = '{OP_AND, 32'hffffffff,  32'h80000001,  5'd20};
    endtask

    // Four-phase dispatch, ack sampled mid-cycle
    task automatic dispatch(input disp_t d);
        @(posedge clk);
        disp     <= d;
        disp_req <= 1'b1;
        do @(negedge clk); while (!disp_ack);
        @(posedge clk);
        disp_req <= 1'b0;
        do @(negedge clk); while (disp_ack);
    endtask

    // Commit monitor
    always @(negedge clk) begin
        if (!rst && commit.valid) begin
            if (exp_q.size() == 0) begin
                $display("Commit of tag %0d at %0t with no instruction outstanding",
                         commit.tag, $time);
                errors++;
            end else begin
                e = exp_q.pop_front();
                check_equal(commit.value, e.value, "commit value");
                check_equal(32'(commit.dest), 32'(e.dest), "commit dest");
                check_equal(32'(commit.tag), 32'(exp_tag), "commit tag");
            end
            committed++;
            exp_tag++;                              // Wraps with ROB depth
        end
    end

    // Run limit
    always @(posedge clk) begin
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, %0d of %0d instructions committed, %0d errors",
                     cycles, committed, NROWS, errors);
            $display("RESULT: FAIL");
            $finish;
        end else begin
            cycles <= cycles + 1;
        end
    end

    initial begin
        disp_req  = 1'b0;
        disp      = '0;
        errors    = 0;
        committed = 0;
        cycles    = 0;
        exp_tag   = '0;
        void'($urandom(32'hbb2247a0));              // Seed once
        load_rows();
        wait (rst === 1'b0);
        for (int i = 0; i < NROWS; i++) begin
            gap = $urandom % 4;                     // Idle gap before dispatch
            repeat (gap) @(posedge clk);
            exp_q.push_back('{dest: rows[i].dest, value: expected_result(rows[i])});
            dispatch(rows[i]);
        end
        while (committed < NROWS) @(negedge clk);
        repeat (20) @(negedge clk);                 // Catch late duplicates
        check_equal(32'(committed), 32'(NROWS), "committed count");
        $display("Done: %0d of %0d committed, %0d errors", committed, NROWS, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end
endmodule

// ==== verilog/cdb_arbiter.sv ====
module cdb_arbiter import ooo_pkg::*; #(
    parameter type payload_t = cdb_t
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     [1:0] req,                     // 0 int, 1 div
    input  payload_t res_int,
    input  payload_t res_div,
    output logic     [1:0] ack,
    output payload_t cdb
);
    logic [1:0] pend;                               // Requests not yet acked
    logic [1:0] grant;
    logic       last;                               // Previous winner

    assign pend = req & ~ack;

    // One handshake in flight at a time on the shared bus
    always_comb begin
        grant = 2'b00;
        if (ack == 2'b00) begin
            if (pend == 2'b11)
                grant = last ? 2'b01 : 2'b10;       // Favour the other unit
            else
                grant = pend;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack  <= 2'b00;
            last <= 1'b0;
            cdb  <= '0;
        end else begin
            ack <= (ack & req) | grant;             // Release once req drops
            if (grant[0])
                cdb <= res_int;
            else if (grant[1])
                cdb <= res_div;
            else
                cdb <= '0;                          // Bus idle, valid low
            if (|grant)
                last <= grant[1];
        end
    end

    a_ack_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(ack));

endmodule

// ==== verilog/div_exec.sv ====
`include "ooo_settings.svh"

module div_exec import ooo_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  issue_t issue,
    input  logic   ack,
    output logic   busy,
    output logic   req,
    output cdb_t   res
);
    localparam int XLEN = `OOO_XLEN;
    localparam int N    = `OOO_DIV_CYCLES;
    localparam int CW   = $clog2(N + 1);

    logic            running;                       // Iterating
    logic [CW-1:0]   cnt;                           // Quotient bits left
    tag_t            tag_q;
    logic [XLEN-1:0] divisor;
    logic [XLEN-1:0] rem;                           // Partial remainder
    logic [XLEN-1:0] quo;                           // Dividend shifts out, quotient in
    logic [XLEN:0]   shifted, rem_next;
    logic            take;

    // Restoring step, bring in next dividend bit
    assign shifted  = {rem, quo[XLEN-1]};
    assign take     = shifted >= {1'b0, divisor};   // Zero divisor always takes
    assign rem_next = take ? (shifted - {1'b0, divisor}) : shifted;

    assign busy = running || req;                   // Held until result acked
    assign res  = '{valid: req, tag: tag_q, value: quo};

    always_ff @(posedge clk) begin
        if (issue.valid) begin
            tag_q   <= issue.tag;
            divisor <= issue.b;
            quo     <= issue.a;
            rem     <= '0;
        end else if (running) begin
            rem <= rem_next[XLEN-1:0];
            quo <= {quo[XLEN-2:0], take};           // All ones when divisor is 0
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            running <= 1'b0;
            cnt     <= '0;
            req     <= 1'b0;
        end else begin
            if (issue.valid) begin
                running <= 1'b1;
                cnt     <= CW'(N);
            end else if (running) begin
                cnt <= cnt - 1'b1;
                if (cnt == CW'(1)) begin
                    running <= 1'b0;                // Last bit lands this edge
                    req     <= 1'b1;
                end
            end
            if (req && ack)
                req <= 1'b0;                        // Result on bus
        end
    end

    // ROB must honour busy across the registered issue path
    a_no_issue_busy: assert property (@(posedge clk) disable iff (rst)
        issue.valid |-> !busy);

endmodule

// ==== verilog/int_exec.sv ====
`include "ooo_settings.svh"

module int_exec import ooo_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  issue_t issue,
    input  logic   ack,
    output logic   busy,
    output logic   req,
    output cdb_t   res
);
    localparam int XLEN = `OOO_XLEN;
    localparam int H    = XLEN / 2;                 // Multiplier split point
    localparam int QD   = `OOO_INT_QDEPTH;
    localparam int PW   = (QD > 1) ? $clog2(QD) : 1;
    localparam int CW   = $clog2(QD + 1);

    logic            s1_valid;                      // Stage 1 occupied
    tag_t            s1_tag;
    logic            s1_is_mul;
    logic [XLEN-1:0] s1_alu, s1_plo, s1_phi;        // ALU result, partial products
    logic [XLEN-1:0] b_lo, b_hi, alu_val, s2_value;
    logic            q_push, q_pop;
    logic [PW-1:0]   q_wr, q_rd;
    logic [CW-1:0]   q_count;
    tag_t            q_tag   [QD];
    logic [XLEN-1:0] q_value [QD];

    assign b_lo = {{(XLEN-H){1'b0}}, issue.b[H-1:0]};
    assign b_hi = {{H{1'b0}}, issue.b[XLEN-1:H]};

    always_comb begin
        case (issue.op)
            OP_ADD:  alu_val = issue.a + issue.b;
            OP_SUB:  alu_val = issue.a - issue.b;
            OP_AND:  alu_val = issue.a & issue.b;
            OP_OR:   alu_val = issue.a | issue.b;
            OP_XOR:  alu_val = issue.a ^ issue.b;
            default: alu_val = '0;                  // Div never routed here
        endcase
    end

    // Second stage folds the upper partial product back in
    assign s2_value = s1_is_mul ? (s1_plo + (s1_phi << H)) : s1_alu;
    assign q_push   = s1_valid;
    assign q_pop    = req && ack;                   // Result taken by arbiter
    assign busy     = (int'(q_count) + int'(s1_valid) + int'(issue.valid)) >= QD;
    assign res      = '{valid: req, tag: q_tag[q_rd], value: q_value[q_rd]};

    always_ff @(posedge clk) begin
        s1_tag    <= issue.tag;
        s1_is_mul <= (issue.op == OP_MUL);
        s1_alu    <= alu_val;
        s1_plo    <= issue.a * b_lo;                // Low half product
        s1_phi    <= issue.a * b_hi;                // High half, wraps on shift
        if (q_push) begin
            q_tag[q_wr]   <= s1_tag;
            q_value[q_wr] <= s2_value;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid <= 1'b0;
            q_wr     <= '0;
            q_rd     <= '0;
            q_count  <= '0;
            req      <= 1'b0;
        end else begin
            s1_valid <= issue.valid;
            if (q_push)
                q_wr <= (q_wr == PW'(QD - 1)) ? '0 : q_wr + 1'b1;
            if (q_pop)
                q_rd <= (q_rd == PW'(QD - 1)) ? '0 : q_rd + 1'b1;
            q_count <= q_count + CW'(q_push) - CW'(q_pop);
            if (q_pop)
                req <= 1'b0;                        // Phase 3, drop request
            else if (!req && !ack && q_count != '0)
                req <= 1'b1;                        // Previous ack released
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        q_push |-> (int'(q_count) < QD) || q_pop);

endmodule

// ==== verilog/ooo_core_top.sv ====
module ooo_core_top import ooo_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    disp_req,
    input  disp_t   disp,
    output logic    disp_ack,
    output commit_t commit
);
    issue_t     int_issue, div_issue;               // ROB to units
    logic       int_busy, div_busy;
    logic       int_req, div_req;                   // Units to arbiter
    cdb_t       int_res, div_res;
    logic [1:0] arb_ack;                            // Bit 0 int, bit 1 div
    cdb_t       cdb;                                // Shared result bus

    reorder_buffer i_reorder_buffer (
        .clk       (clk),
        .rst       (rst),
        .disp_req  (disp_req),
        .disp      (disp),
        .int_busy  (int_busy),
        .div_busy  (div_busy),
        .cdb       (cdb),
        .disp_ack  (disp_ack),
        .int_issue (int_issue),
        .div_issue (div_issue),
        .commit    (commit)
    );

    int_exec i_int_exec (
        .clk   (clk),
        .rst   (rst),
        .issue (int_issue),
        .ack   (arb_ack[0]),
        .busy  (int_busy),
        .req   (int_req),
        .res   (int_res)
    );

    div_exec i_div_exec (
        .clk   (clk),
        .rst   (rst),
        .issue (div_issue),
        .ack   (arb_ack[1]),
        .busy  (div_busy),
        .req   (div_req),
        .res   (div_res)
    );

    cdb_arbiter #(.payload_t(cdb_t)) i_cdb_arbiter (
        .clk     (clk),
        .rst     (rst),
        .req     ({div_req, int_req}),
        .res_int (int_res),
        .res_div (div_res),
        .ack     (arb_ack),
        .cdb     (cdb)
    );

endmodule

// ==== verilog/ooo_pkg.sv ====
`include "ooo_settings.svh"

package ooo_pkg;

    typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0] tag_t;   // ROB index

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_MUL = 3'd5,
        OP_DIV = 3'd6                   // Only op routed to divider
    } op_e;

    typedef struct packed {
        op_e                  op;
        logic [`OOO_XLEN-1:0] a;
        logic [`OOO_XLEN-1:0] b;
        logic [4:0]           dest;     // Architectural dest reg
    } disp_t;

    typedef struct packed {
        logic                 valid;    // One-cycle issue pulse
        tag_t                 tag;
        op_e                  op;
        logic [`OOO_XLEN-1:0] a;
        logic [`OOO_XLEN-1:0] b;
    } issue_t;

    typedef struct packed {
        logic                 valid;
        tag_t                 tag;
        logic [`OOO_XLEN-1:0] value;
    } cdb_t;

    typedef struct packed {
        logic                 valid;
        tag_t                 tag;
        logic [4:0]           dest;
        logic [`OOO_XLEN-1:0] value;
    } commit_t;

endpackage

// ==== verilog/ooo_settings.svh ====
`ifndef OOO_SETTINGS_SVH
`define OOO_SETTINGS_SVH

// Core sizing
`define OOO_XLEN        32              // Data path width
`define OOO_ROB_DEPTH   8               // ROB entries, power of two

// Execution unit timing
`define OOO_MUL_STAGES  2               // Integer unit latency in cycles
`define OOO_INT_QDEPTH  2               // Integer result queue entries
`define OOO_DIV_CYCLES  `OOO_XLEN       // One quotient bit per cycle

`endif

// ==== verilog/reorder_buffer.sv ====
`include "ooo_settings.svh"

module reorder_buffer import ooo_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    disp_req,
    input  disp_t   disp,
    input  logic    int_busy,
    input  logic    div_busy,
    input  cdb_t    cdb,
    output logic    disp_ack,
    output issue_t  int_issue,
    output issue_t  div_issue,
    output commit_t commit
);
    localparam int DEPTH = `OOO_ROB_DEPTH;
    localparam int CW    = $clog2(DEPTH) + 1;

    logic [DEPTH-1:0]     ent_valid;                // Allocated
    logic [DEPTH-1:0]     ent_ready;                // Result written
    logic [4:0]           ent_dest  [DEPTH];
    logic [`OOO_XLEN-1:0] ent_value [DEPTH];
    tag_t                 head;                     // Oldest entry
    tag_t                 tail;                     // Next free slot
    logic [CW-1:0]        count;
    logic                 to_div;
    logic                 tgt_busy;
    logic                 accept;
    logic                 retire;

    assign to_div   = (disp.op == OP_DIV);
    assign tgt_busy = to_div ? div_busy : int_busy;
    assign accept   = disp_req && !disp_ack && (count != CW'(DEPTH)) && !tgt_busy;
    assign retire   = ent_valid[head] && ent_ready[head];   // In-order only

    // Entry payload
    always_ff @(posedge clk) begin
        if (accept)
            ent_dest[tail] <= disp.dest;
        if (cdb.valid)
            ent_value[cdb.tag] <= cdb.value;        // Writeback by tag
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ent_valid       <= '0;
            ent_ready       <= '0;
            head            <= '0;
            tail            <= '0;
            count           <= '0;
            disp_ack        <= 1'b0;
            int_issue.valid <= 1'b0;
            div_issue.valid <= 1'b0;
            commit.valid    <= 1'b0;
        end else begin
            // Dispatch handshake
            if (accept)
                disp_ack <= 1'b1;
            else if (!disp_req)
                disp_ack <= 1'b0;                   // Four-phase return to zero

            if (accept) begin
                ent_valid[tail] <= 1'b1;
                ent_ready[tail] <= 1'b0;
                tail            <= tail + 1'b1;     // Wraps, depth is 2^n
            end

            // Issue routing, pulse for one cycle
            int_issue.valid <= accept && !to_div;
            div_issue.valid <= accept && to_div;
            if (accept) begin
                int_issue.tag <= tail;
                int_issue.op  <= disp.op;
                int_issue.a   <= disp.a;
                int_issue.b   <= disp.b;
                div_issue.tag <= tail;
                div_issue.op  <= disp.op;
                div_issue.a   <= disp.a;
                div_issue.b   <= disp.b;
            end

            if (cdb.valid)
                ent_ready[cdb.tag] <= 1'b1;

            // Retire from head
            commit.valid <= retire;
            if (retire) begin
                commit.tag      <= head;
                commit.dest     <= ent_dest[head];
                commit.value    <= ent_value[head];
                ent_valid[head] <= 1'b0;
                ent_ready[head] <= 1'b0;
                head            <= head + 1'b1;
            end

            count <= count + CW'(accept) - CW'(retire);
        end
    end

    // Result must belong to an instruction still in flight
    a_cdb_live: assert property (@(posedge clk) disable iff (rst)
        cdb.valid |-> ent_valid[cdb.tag]);
    a_count_max: assert property (@(posedge clk) disable iff (rst)
        count <= CW'(DEPTH));

endmodule
